//--- Bender.yml
package:
  name: cpu

sources:
  - files:
      - design/cpu_pkg.sv
      - design/reg_file.sv
      - design/fetch_unit.sv
      - design/instr_decoder.sv
      - design/controller.sv
      - design/datapath.sv
      - design/cpu.sv
  - target: simulation
    files:
      - verification/tb_clock.sv
      - verification/controller_chk.sv
      - verification/cpu_tb.sv

//--- design/controller.sv
// one instruction in flight, no memory wait states; HALT and every undefined encoding stop until reset
`timescale 1ns/1ps
`default_nettype none

module controller (
	input  wire                  clk,
	input  wire                  reset,
	input  cpu_pkg::opcode_t     opcode,
	input  cpu_pkg::alu_op_t     op,
	output logic                 reset_pc,
	output logic                 load_pc,
	output logic                 load_ir,
	output logic                 load_addr,
	output logic                 addr_sel,
	output cpu_pkg::mem_cmd_t    mem_cmd,
	output cpu_pkg::reg_sel_t    reg_sel,
	output logic                 load_a,
	output logic                 load_b,
	output logic                 load_c,
	output logic                 a_zero,
	output logic                 b_imm,
	output logic                 reg_write,
	output cpu_pkg::wb_sel_t     wb_sel
);

	typedef enum logic [4:0] {
		st_reset, st_fetch1, st_fetch2, st_update,
		st_mov_imm,
		st_unary1, st_unary2, st_unary3, // MOV register and MVN
		st_alu1, st_alu2, st_alu3, st_alu4,
		st_ldr1, st_ldr2, st_ldr3, st_ldr4, st_ldr5, st_ldr6,
		st_str1, st_str2, st_str3, st_str4, st_str5, st_str6, st_str7, st_str8,
		st_halt
	} state_t;

	state_t state;
	state_t state_next;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_reset;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = st_halt; // unused encodings park safely
		case (state)
			st_reset:  state_next = st_fetch1;
			st_fetch1: state_next = st_fetch2;
			st_fetch2: state_next = st_update;
			st_update: begin
				case (opcode)
					cpu_pkg::opc_mov: begin
						if (op == cpu_pkg::op_mov_imm) state_next = st_mov_imm;
						else if (op == cpu_pkg::op_mov_reg) state_next = st_unary1;
					end
					cpu_pkg::opc_alu: begin
						if (op == cpu_pkg::op_add || op == cpu_pkg::op_and) state_next = st_alu1;
						else if (op == cpu_pkg::op_mvn) state_next = st_unary1;
					end
					cpu_pkg::opc_ldr: if (op == cpu_pkg::op_mem) state_next = st_ldr1;
					cpu_pkg::opc_str: if (op == cpu_pkg::op_mem) state_next = st_str1;
					cpu_pkg::opc_halt: state_next = st_halt;
					default: state_next = st_halt; // CMP and the rest are undefined
				endcase
			end
			st_unary1: state_next = st_unary2;
			st_unary2: state_next = st_unary3;
			st_alu1:   state_next = st_alu2;
			st_alu2:   state_next = st_alu3;
			st_alu3:   state_next = st_alu4;
			st_ldr1:   state_next = st_ldr2;
			st_ldr2:   state_next = st_ldr3;
			st_ldr3:   state_next = st_ldr4;
			st_ldr4:   state_next = st_ldr5;
			st_ldr5:   state_next = st_ldr6;
			st_str1:   state_next = st_str2;
			st_str2:   state_next = st_str3;
			st_str3:   state_next = st_str4;
			st_str4:   state_next = st_str5;
			st_str5:   state_next = st_str6;
			st_str6:   state_next = st_str7;
			st_str7:   state_next = st_str8;
			st_mov_imm, st_unary3, st_alu4, st_ldr6, st_str8: state_next = st_fetch1;
			st_halt:   state_next = st_halt;
			default:   state_next = st_halt;
		endcase
	end

	always_comb begin
		reset_pc = 1'b0;
		load_pc = 1'b0;
		load_ir = 1'b0;
		load_addr = 1'b0;
		addr_sel = 1'b0; // data address unless fetching
		mem_cmd = cpu_pkg::mem_none;
		reg_sel = cpu_pkg::sel_rn;
		load_a = 1'b0;
		load_b = 1'b0;
		load_c = 1'b0;
		a_zero = 1'b0;
		b_imm = 1'b0;
		reg_write = 1'b0;
		wb_sel = cpu_pkg::wb_c;
		case (state)
			st_reset, st_halt: begin
				reset_pc = 1'b1; // PC held at reset_addr
				load_pc = 1'b1;
			end
			st_fetch1: begin
				mem_cmd = cpu_pkg::mem_read;
				addr_sel = 1'b1;
			end
			st_fetch2: begin
				mem_cmd = cpu_pkg::mem_read;
				addr_sel = 1'b1;
				load_ir = 1'b1;
			end
			st_update: load_pc = 1'b1; // PC + 1
			st_mov_imm: begin
				wb_sel = cpu_pkg::wb_imm8; // into Rn
				reg_write = 1'b1;
			end
			st_alu1, st_ldr1, st_str1: load_a = 1'b1; // A <= Rn
			st_unary1, st_alu2: begin
				reg_sel = cpu_pkg::sel_rm;
				load_b = 1'b1;
			end
			st_alu3: load_c = 1'b1;
			st_unary2, st_str5: begin
				a_zero = 1'b1; // C <= op(0, B)
				load_c = 1'b1;
			end
			st_ldr2, st_str2: begin
				b_imm = 1'b1; // C <= Rn + offset
				load_c = 1'b1;
			end
			st_ldr3, st_str3: load_addr = 1'b1;
			st_unary3, st_alu4: begin
				reg_sel = cpu_pkg::sel_rd;
				reg_write = 1'b1;
			end
			st_ldr4, st_ldr5: mem_cmd = cpu_pkg::mem_read;
			st_ldr6: begin
				mem_cmd = cpu_pkg::mem_read;
				reg_sel = cpu_pkg::sel_rd;
				wb_sel = cpu_pkg::wb_mdata;
				reg_write = 1'b1;
			end
			st_str4: begin
				reg_sel = cpu_pkg::sel_rd; // store data
				load_b = 1'b1;
			end
			st_str6, st_str7, st_str8: mem_cmd = cpu_pkg::mem_write;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- design/cpu.sv
// memory must answer reads combinationally and accept a write every cycle; there is no stall input
`timescale 1ns/1ps
`default_nettype none

module cpu #(
	parameter cpu_pkg::mem_addr_t reset_addr = '0
) (
	input  wire                 clk,
	input  wire                 reset,
	input  cpu_pkg::data_word_t read_data,
	output cpu_pkg::mem_cmd_t   mem_cmd,
	output cpu_pkg::mem_addr_t  mem_addr,
	output cpu_pkg::data_word_t write_data
);

	logic reset_pc;
	logic load_pc;
	logic load_ir;
	logic load_addr;
	logic addr_sel;
	logic load_a;
	logic load_b;
	logic load_c;
	logic a_zero;
	logic b_imm;
	logic reg_write;
	cpu_pkg::reg_sel_t reg_sel;
	cpu_pkg::wb_sel_t wb_sel;
	cpu_pkg::data_word_t instr;
	cpu_pkg::opcode_t opcode;
	cpu_pkg::alu_op_t op;
	cpu_pkg::alu_op_t alu_op;
	cpu_pkg::shift_t shift;
	cpu_pkg::reg_num_t reg_num;
	cpu_pkg::data_word_t imm5_ext;
	cpu_pkg::data_word_t imm8_ext;

	fetch_unit #(
		.reset_addr (reset_addr)
	) i_fetch_unit (
		.clk         (clk),
		.reset_pc    (reset_pc),
		.load_pc     (load_pc),
		.load_ir     (load_ir),
		.load_addr   (load_addr),
		.addr_sel    (addr_sel),
		.read_data   (read_data),
		.result_addr (write_data[cpu_pkg::addr_width-1:0]), // C doubles as the address
		.instr       (instr),
		.mem_addr    (mem_addr)
	);

	instr_decoder i_instr_decoder (
		.instr    (instr),
		.reg_sel  (reg_sel),
		.opcode   (opcode),
		.op       (op),
		.alu_op   (alu_op),
		.shift    (shift),
		.reg_num  (reg_num),
		.imm5_ext (imm5_ext),
		.imm8_ext (imm8_ext)
	);

	controller i_controller (
		.clk       (clk),
		.reset     (reset),
		.opcode    (opcode),
		.op        (op),
		.reset_pc  (reset_pc),
		.load_pc   (load_pc),
		.load_ir   (load_ir),
		.load_addr (load_addr),
		.addr_sel  (addr_sel),
		.mem_cmd   (mem_cmd),
		.reg_sel   (reg_sel),
		.load_a    (load_a),
		.load_b    (load_b),
		.load_c    (load_c),
		.a_zero    (a_zero),
		.b_imm     (b_imm),
		.reg_write (reg_write),
		.wb_sel    (wb_sel)
	);

	datapath i_datapath (
		.clk       (clk),
		.reg_num   (reg_num),
		.reg_write (reg_write),
		.wb_sel    (wb_sel),
		.load_a    (load_a),
		.load_b    (load_b),
		.load_c    (load_c),
		.a_zero    (a_zero),
		.b_imm     (b_imm),
		.alu_op    (alu_op),
		.shift     (shift),
		.imm5_ext  (imm5_ext),
		.imm8_ext  (imm8_ext),
		.read_data (read_data),
		.result    (write_data) // store data is always C
	);

endmodule

`default_nettype wire

//--- design/cpu_pkg.sv
// shared widths and encodings; any opcode/op pair not listed here is undefined and halts the cpu
`default_nettype none

package cpu_pkg;
	localparam int data_width = 16;
	localparam int addr_width = 9; // 512-word memory space

	typedef logic [data_width-1:0] data_word_t;
	typedef logic [addr_width-1:0] mem_addr_t;
	typedef logic [2:0] reg_num_t;
	typedef logic [2:0] opcode_t;
	typedef logic [1:0] alu_op_t;
	typedef logic [1:0] shift_t;

	typedef enum logic [1:0] {mem_none = 2'b00, mem_read = 2'b01, mem_write = 2'b10} mem_cmd_t;
	typedef enum logic [1:0] {sel_rn, sel_rd, sel_rm} reg_sel_t;
	typedef enum logic [1:0] {wb_c, wb_imm8, wb_mdata} wb_sel_t;

	localparam opcode_t opc_mov = 3'b110;
	localparam opcode_t opc_alu = 3'b101;
	localparam opcode_t opc_ldr = 3'b011;
	localparam opcode_t opc_str = 3'b100;
	localparam opcode_t opc_halt = 3'b111;

	localparam alu_op_t op_mov_imm = 2'b10;
	localparam alu_op_t op_mov_reg = 2'b00;
	localparam alu_op_t op_add = 2'b00;
	localparam alu_op_t op_and = 2'b10;
	localparam alu_op_t op_mvn = 2'b11;
	localparam alu_op_t op_mem = 2'b00; // LDR and STR

	localparam shift_t shift_none = 2'b00;
	localparam shift_t shift_left = 2'b01;
	localparam shift_t shift_lsr = 2'b10; // logical right by one
	localparam shift_t shift_asr = 2'b11; // arithmetic right by one

	localparam int pos_opcode = 13; // lsb of each field
	localparam int pos_op = 11;
	localparam int pos_rn = 8;
	localparam int pos_rd = 5;
	localparam int pos_shift = 3;
	localparam int pos_rm = 0;
	localparam int imm8_width = 8; // both immediates start at bit 0
	localparam int imm5_width = 5;
endpackage

`default_nettype wire

//--- design/datapath.sv
// no flags are kept; op code 01 (former CMP) never reaches here because the controller halts on it
`timescale 1ns/1ps
`default_nettype none

module datapath (
	input  wire                 clk,
	input  cpu_pkg::reg_num_t   reg_num,
	input  wire                 reg_write,
	input  cpu_pkg::wb_sel_t    wb_sel,
	input  wire                 load_a,
	input  wire                 load_b,
	input  wire                 load_c,
	input  wire                 a_zero,
	input  wire                 b_imm,
	input  cpu_pkg::alu_op_t    alu_op,
	input  cpu_pkg::shift_t     shift,
	input  cpu_pkg::data_word_t imm5_ext,
	input  cpu_pkg::data_word_t imm8_ext,
	input  cpu_pkg::data_word_t read_data,
	output cpu_pkg::data_word_t result
);

	cpu_pkg::data_word_t rdata;
	cpu_pkg::data_word_t wdata;
	cpu_pkg::data_word_t a_reg;
	cpu_pkg::data_word_t b_reg;
	cpu_pkg::data_word_t b_shifted;
	cpu_pkg::data_word_t ain;
	cpu_pkg::data_word_t bin;
	cpu_pkg::data_word_t alu_out;

	reg_file i_reg_file (
		.clk   (clk),
		.write (reg_write),
		.num   (reg_num),
		.wdata (wdata),
		.rdata (rdata)
	);

	always_ff @(posedge clk) begin
		if (load_a) a_reg <= rdata;
		if (load_b) b_reg <= rdata;
		if (load_c) result <= alu_out; // C register
	end

	always_comb begin
		case (shift)
			cpu_pkg::shift_left: b_shifted = b_reg << 1;
			cpu_pkg::shift_lsr:  b_shifted = b_reg >> 1;
			cpu_pkg::shift_asr:  b_shifted = {b_reg[cpu_pkg::data_width-1],
				b_reg[cpu_pkg::data_width-1:1]};
			default:             b_shifted = b_reg;
		endcase
	end

	assign ain = a_zero ? '0 : a_reg;
	assign bin = b_imm ? imm5_ext : b_shifted; // offset for LDR/STR

	always_comb begin
		case (alu_op)
			cpu_pkg::op_and: alu_out = ain & bin;
			cpu_pkg::op_mvn: alu_out = ~bin;
			default:         alu_out = ain + bin; // ADD, MOV register, address sum
		endcase
	end

	always_comb begin
		case (wb_sel)
			cpu_pkg::wb_imm8:  wdata = imm8_ext;
			cpu_pkg::wb_mdata: wdata = read_data;
			default:           wdata = result;
		endcase
	end

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
// registers power up unknown; the controller's reset state loads reset_addr into the PC
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter cpu_pkg::mem_addr_t reset_addr = '0
) (
	input  wire                    clk,
	input  wire                    reset_pc,
	input  wire                    load_pc,
	input  wire                    load_ir,
	input  wire                    load_addr,
	input  wire                    addr_sel,
	input  cpu_pkg::data_word_t    read_data,
	input  cpu_pkg::mem_addr_t     result_addr,
	output cpu_pkg::data_word_t    instr,
	output cpu_pkg::mem_addr_t     mem_addr
);

	cpu_pkg::mem_addr_t pc;
	cpu_pkg::mem_addr_t next_pc;
	cpu_pkg::mem_addr_t data_addr;

	assign next_pc = reset_pc ? reset_addr : cpu_pkg::mem_addr_t'(pc + 1'b1); // wraps at top

	always_ff @(posedge clk) begin
		if (load_pc) begin
			pc <= next_pc;
		end
		if (load_ir) begin
			instr <= read_data; // read data is valid in the second fetch cycle
		end
		if (load_addr) begin
			data_addr <= result_addr; // low bits of C
		end
	end

	assign mem_addr = addr_sel ? pc : data_addr; // 1 = instruction fetch

endmodule

`default_nettype wire

//--- design/instr_decoder.sv
// purely combinational; the one register number serves both the read and the write port
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input  cpu_pkg::data_word_t instr,
	input  cpu_pkg::reg_sel_t   reg_sel,
	output cpu_pkg::opcode_t    opcode,
	output cpu_pkg::alu_op_t    op,
	output cpu_pkg::alu_op_t    alu_op,
	output cpu_pkg::shift_t     shift,
	output cpu_pkg::reg_num_t   reg_num,
	output cpu_pkg::data_word_t imm5_ext,
	output cpu_pkg::data_word_t imm8_ext
);

	logic mem_instr;

	assign opcode = instr[cpu_pkg::pos_opcode +: $bits(cpu_pkg::opcode_t)];
	assign op = instr[cpu_pkg::pos_op +: $bits(cpu_pkg::alu_op_t)];
	assign alu_op = op; // same field, the controller and the ALU each read it

	// shift bits of LDR/STR are part of the offset
	assign mem_instr = (opcode == cpu_pkg::opc_ldr) || (opcode == cpu_pkg::opc_str);
	assign shift = mem_instr ? cpu_pkg::shift_none
		: instr[cpu_pkg::pos_shift +: $bits(cpu_pkg::shift_t)];

	assign imm5_ext = {{(cpu_pkg::data_width - cpu_pkg::imm5_width){instr[cpu_pkg::imm5_width-1]}},
		instr[cpu_pkg::imm5_width-1:0]};
	assign imm8_ext = {{(cpu_pkg::data_width - cpu_pkg::imm8_width){instr[cpu_pkg::imm8_width-1]}},
		instr[cpu_pkg::imm8_width-1:0]};

	always_comb begin
		case (reg_sel)
			cpu_pkg::sel_rd: reg_num = instr[cpu_pkg::pos_rd +: $bits(cpu_pkg::reg_num_t)];
			cpu_pkg::sel_rm: reg_num = instr[cpu_pkg::pos_rm +: $bits(cpu_pkg::reg_num_t)];
			default:         reg_num = instr[cpu_pkg::pos_rn +: $bits(cpu_pkg::reg_num_t)];
		endcase
	end

endmodule

`default_nettype wire

//--- design/reg_file.sv
// read and write share one register number; a write shows on rdata only after the clock edge
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire                 clk,
	input  wire                 write,
	input  cpu_pkg::reg_num_t   num,
	input  cpu_pkg::data_word_t wdata,
	output cpu_pkg::data_word_t rdata
);

	cpu_pkg::data_word_t regs [8]; // R0..R7, contents unknown after reset

	always_ff @(posedge clk) begin
		if (write) begin
			regs[num] <= wdata;
		end
	end

	assign rdata = regs[num];

endmodule

`default_nettype wire

//--- list.f
design/cpu_pkg.sv
design/reg_file.sv
design/fetch_unit.sv
design/instr_decoder.sv
design/controller.sv
design/datapath.sv
design/cpu.sv
verification/tb_clock.sv
verification/controller_chk.sv
verification/cpu_tb.sv

//--- verification/controller_chk.sv
// bound into controller; the reset-state check needs reset held across at least one clock edge
`timescale 1ns/1ps
`default_nettype none

module controller_chk (
	input wire               clk,
	input wire               reset,
	input cpu_pkg::mem_cmd_t mem_cmd,
	input wire               reset_pc,
	input wire               load_pc,
	input wire               load_ir,
	input wire               load_addr,
	input wire               load_a,
	input wire               load_b,
	input wire               load_c,
	input wire               a_zero,
	input wire               b_imm,
	input wire               reg_write
);

	int fail_count = 0; // assertion failures so far

	cmd_legal: assert property (@(posedge clk) disable iff (reset)
		mem_cmd inside {cpu_pkg::mem_none, cpu_pkg::mem_read, cpu_pkg::mem_write})
		else begin
			$error("mem_cmd holds the unused encoding");
			fail_count++;
		end

	ir_needs_read: assert property (@(posedge clk) disable iff (reset)
		load_ir |-> mem_cmd == cpu_pkg::mem_read)
		else begin
			$error("load_ir active without a memory read");
			fail_count++;
		end

	no_write_clash: assert property (@(posedge clk) disable iff (reset)
		!(reg_write && mem_cmd == cpu_pkg::mem_write))
		else begin
			$error("reg_write and mem_write active in the same cycle");
			fail_count++;
		end

	// reset state: only the PC reload is active
	reset_quiet: assert property (@(posedge clk)
		reset |=> (reset_pc && load_pc && !load_ir && !load_addr && !load_a && !load_b
			&& !load_c && !a_zero && !b_imm && !reg_write && mem_cmd == cpu_pkg::mem_none))
		else begin
			$error("strobes active in the cycle after reset");
			fail_count++;
		end

endmodule

`default_nettype wire

//--- verification/cpu_tb.sv
// one random program from reset_addr; its final stores go to 0x70..0x77, so the program must end below
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
	localparam cpu_pkg::mem_addr_t reset_addr = 9'h020;
	localparam cpu_pkg::mem_addr_t store_base = 9'h070;
	localparam int random_count = 40;
	localparam int run_timeout = 5000; // cycles
	localparam int quiet_cycles = 50;

	logic clk;
	logic reset;
	cpu_pkg::data_word_t read_data;
	cpu_pkg::mem_cmd_t mem_cmd;
	cpu_pkg::mem_addr_t mem_addr;
	cpu_pkg::data_word_t write_data;

	cpu_pkg::data_word_t mem [512];
	cpu_pkg::data_word_t model_mem [512];
	cpu_pkg::data_word_t model_regs [8];
	cpu_pkg::mem_cmd_t exp_cmd [$];
	cpu_pkg::mem_addr_t exp_addr [$];
	cpu_pkg::data_word_t exp_data [$];
	string exp_name [$];
	logic [15:0] lfsr;
	int error_count;
	int timeout_count;

	tb_clock #(.period_ns(8), .reset_cycles(10)) i_tb_clock (.clk(clk), .reset(reset));

	cpu #(.reset_addr(reset_addr)) i_dut (
		.clk        (clk),
		.reset      (reset),
		.read_data  (read_data),
		.mem_cmd    (mem_cmd),
		.mem_addr   (mem_addr),
		.write_data (write_data)
	);

	bind controller controller_chk i_controller_chk (
		.clk       (clk),
		.reset     (reset),
		.mem_cmd   (mem_cmd),
		.reset_pc  (reset_pc),
		.load_pc   (load_pc),
		.load_ir   (load_ir),
		.load_addr (load_addr),
		.load_a    (load_a),
		.load_b    (load_b),
		.load_c    (load_c),
		.a_zero    (a_zero),
		.b_imm     (b_imm),
		.reg_write (reg_write)
	);

	assign read_data = mem[mem_addr]; // combinational read port

	always @(posedge clk) begin
		if (mem_cmd == cpu_pkg::mem_write) mem[mem_addr] <= write_data;
	end

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1); // galois, x^16+x^14+x^13+x^11+1
	endfunction

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic cpu_pkg::data_word_t fill_word(input cpu_pkg::mem_addr_t a);
		return {a[6:0], a} ^ 16'ha5c3;
	endfunction

	function automatic cpu_pkg::data_word_t shifted_word(input cpu_pkg::data_word_t v,
		input cpu_pkg::shift_t sh);
		case (sh)
			2'b01: return v << 1;
			2'b10: return v >> 1;
			2'b11: return {v[15], v[15:1]}; // sign kept
			default: return v;
		endcase
	endfunction

	task automatic check_word(input string test, input cpu_pkg::data_word_t exp,
		input cpu_pkg::data_word_t act);
		if (act !== exp) begin
			error_count++;
			$display("Error %s: expected %h, actual %h", test, exp, act);
		end
	endtask

	task automatic check_addr(input string test, input cpu_pkg::mem_addr_t exp,
		input cpu_pkg::mem_addr_t act);
		if (act !== exp) begin
			error_count++;
			$display("Error %s address: expected %h, actual %h", test, exp, act);
		end
	endtask

	task automatic check_cmd(input string test, input cpu_pkg::mem_cmd_t exp,
		input cpu_pkg::mem_cmd_t act);
		if (act !== exp) begin
			error_count++;
			$display("Error %s command: expected %b, actual %b", test, exp, act);
		end
	endtask

	task automatic expect_access(input string name, input cpu_pkg::mem_cmd_t cmd,
		input cpu_pkg::mem_addr_t addr, input cpu_pkg::data_word_t data, input int count);
		for (int i = 0; i < count; i++) begin
			exp_name.push_back(name);
			exp_cmd.push_back(cmd);
			exp_addr.push_back(addr);
			exp_data.push_back(data);
		end
	endtask

	// seed all registers, random ops, then store every register and halt
	task automatic build_program();
		cpu_pkg::mem_addr_t a;
		logic [2:0] kind;
		logic [10:0] fields;
		a = reset_addr;
		for (int r = 0; r < 8; r++) begin
			mem[a] = {3'b110, 2'b10, 3'(r), 8'(take_bits(8))};
			a++;
		end
		for (int i = 0; i < random_count; i++) begin
			kind = 3'(take_bits(3));
			fields = 11'(take_bits(11)); // Rn, Rd, shift, Rm or offset
			case (kind)
				3'd0, 3'd1: mem[a] = {3'b110, 2'b00, fields}; // MOV register
				3'd2, 3'd7: mem[a] = {3'b101, 2'b00, fields}; // ADD
				3'd3:       mem[a] = {3'b101, 2'b10, fields}; // AND
				3'd4:       mem[a] = {3'b101, 2'b11, fields}; // MVN
				3'd5:       mem[a] = {3'b011, 2'b00, fields}; // LDR
				default:    mem[a] = {3'b110, 2'b10, fields}; // MOV immediate
			endcase
			a++;
		end
		mem[a] = {3'b110, 2'b10, 3'd7, 8'(store_base + 9'd8)}; // R7 sits 8 above the stores
		a++;
		for (int r = 0; r < 8; r++) begin
			mem[a] = {3'b100, 2'b00, 3'd7, 3'(r), 5'(r) - 5'd8}; // offset r - 8, shift bits set
			a++;
		end
		mem[a] = {3'b111, 13'd0};
	endtask

	// instruction-set model, builds the expected bus sequence
	task automatic run_model();
		cpu_pkg::mem_addr_t pc;
		cpu_pkg::mem_addr_t daddr;
		cpu_pkg::data_word_t iw;
		cpu_pkg::data_word_t bval;
		cpu_pkg::data_word_t imm5;
		cpu_pkg::data_word_t imm8;
		cpu_pkg::reg_num_t rn;
		cpu_pkg::reg_num_t rd;
		logic halted;
		int steps;
		pc = reset_addr;
		halted = 1'b0;
		steps = 0;
		while (!halted && steps < 1000) begin
			iw = model_mem[pc];
			expect_access("fetch", cpu_pkg::mem_read, pc, iw, 2);
			pc++;
			steps++;
			rn = iw[10:8];
			rd = iw[7:5];
			bval = shifted_word(model_regs[iw[2:0]], iw[4:3]);
			imm5 = {{11{iw[4]}}, iw[4:0]};
			imm8 = {{8{iw[7]}}, iw[7:0]};
			daddr = cpu_pkg::mem_addr_t'(model_regs[rn] + imm5);
			case (iw[15:11])
				5'b110_10: model_regs[rn] = imm8;
				5'b110_00: model_regs[rd] = bval;
				5'b101_00: model_regs[rd] = model_regs[rn] + bval;
				5'b101_10: model_regs[rd] = model_regs[rn] & bval;
				5'b101_11: model_regs[rd] = ~bval;
				5'b011_00: begin
					expect_access("ldr read", cpu_pkg::mem_read, daddr, model_mem[daddr], 3);
					model_regs[rd] = model_mem[daddr];
				end
				5'b100_00: begin
					expect_access("str write", cpu_pkg::mem_write, daddr, model_regs[rd], 3);
					model_mem[daddr] = model_regs[rd];
				end
				default: halted = 1'b1; // HALT and undefined encodings
			endcase
		end
	endtask

	task automatic compare_access();
		string name;
		cpu_pkg::mem_cmd_t cmd;
		cpu_pkg::data_word_t data;
		name = exp_name.pop_front();
		cmd = exp_cmd.pop_front();
		data = exp_data.pop_front();
		check_cmd(name, cmd, mem_cmd);
		check_addr(name, exp_addr.pop_front(), mem_addr);
		if (cmd == cpu_pkg::mem_write) check_word(name, data, write_data);
	endtask

	initial begin
		int cycles;
		int assert_fails;
		error_count = 0;
		timeout_count = 0;
		lfsr = 16'd8235;
		for (int i = 0; i < 512; i++) mem[i] = fill_word(9'(i));
		for (int r = 0; r < 8; r++) model_regs[r] = '0;
		build_program();
		model_mem = mem;
		run_model();

		cycles = 0;
		while (reset !== 1'b0 && cycles < 100) begin
			@(negedge clk);
			cycles++;
		end
		if (reset !== 1'b0) begin
			$display("Timeout: reset was never released");
			timeout_count++;
		end

		// every bus cycle in order against the model
		cycles = 0;
		while (timeout_count == 0 && exp_cmd.size() != 0 && cycles < run_timeout) begin
			@(negedge clk);
			cycles++;
			if (mem_cmd !== cpu_pkg::mem_none) compare_access();
		end
		if (timeout_count == 0 && exp_cmd.size() != 0) begin
			$display("Timeout: %0d expected memory accesses never happened", exp_cmd.size());
			timeout_count++;
		end

		if (timeout_count == 0) begin
			for (int i = 0; i < quiet_cycles; i++) begin
				@(negedge clk);
				if (mem_cmd !== cpu_pkg::mem_none) begin
					$display("Memory was accessed after HALT at address %h", mem_addr);
					error_count++;
				end
			end
			for (int i = 0; i < 512; i++) check_word("final memory", model_mem[i], mem[i]);
		end

		assert_fails = i_dut.i_controller.i_controller_chk.fail_count;
		$display("errors: %0d, assertion failures: %0d, timeouts: %0d",
			error_count, assert_fails, timeout_count);
		if (error_count == 0 && assert_fails == 0 && timeout_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
// free-running clock from time zero; reset is released 1 ns after the last reset edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int period_ns = 8,
	parameter int reset_cycles = 10
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1 reset = 1'b0; // same input skew as the rest of the stimulus
	end

endmodule

`default_nettype wire
